//--- Makefile
TOP := core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and storage sizes
`define CORE_DATA_WIDTH        32
`define CORE_INSTR_WIDTH       32
`define CORE_REGS_PER_CHANNEL  16
`define CORE_MAX_CHANNELS      4
`define CORE_PROGRAM_DEPTH     256

//////////////////////////////
// Instruction word layout
//////////////////////////////

`define CORE_OPCODE_MSB  31
`define CORE_OPCODE_LSB  27
`define CORE_DEST_MSB    26
`define CORE_DEST_LSB    23
`define CORE_SRC_A_MSB   22
`define CORE_SRC_A_LSB   19
`define CORE_SRC_B_MSB   18
`define CORE_SRC_B_LSB   15

// Immediate is sign-extended to the data width
`define CORE_IMM_MSB     14
`define CORE_IMM_LSB     0

`endif

//--- sources.f
+incdir+include
src/core_pkg.sv
src/instruction_store.sv
src/control_unit.sv
src/decoder.sv
src/register_file.sv
src/alu.sv
src/core_top.sv
verif/core_tb.sv

//--- src/alu.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module alu (
    input  logic                clock,
    input  logic                reset,
    input  logic                exec_valid,
    input  core_pkg::opcode_t   exec_opcode,
    input  core_pkg::reg_addr_t exec_dest,
    input  core_pkg::data_t     exec_immediate,
    input  core_pkg::data_t     operand_a,
    input  core_pkg::data_t     operand_b,
    output logic                result_valid,
    output core_pkg::reg_addr_t result_addr,
    output core_pkg::data_t     result_data
);

    import core_pkg::*;

    localparam int SHIFT_WIDTH = $clog2(`CORE_DATA_WIDTH);

    logic [SHIFT_WIDTH-1:0] shift_amount;
    data_t                  alu_out;

    // Shift distance from the low bits of source B
    assign shift_amount = operand_b[SHIFT_WIDTH-1:0];

    //////////////////////////////
    // Operation select
    //////////////////////////////

    always_comb begin
        case (exec_opcode)
            OP_ADD:  alu_out = operand_a + operand_b;
            OP_SUB:  alu_out = operand_a - operand_b;
            OP_AND:  alu_out = operand_a & operand_b;
            OP_OR:   alu_out = operand_a | operand_b;
            OP_XOR:  alu_out = operand_a ^ operand_b;
            OP_SHL:  alu_out = operand_a << shift_amount;
            OP_SHR:  alu_out = operand_a >> shift_amount;
            OP_LDC:  alu_out = exec_immediate;
            OP_MOV:  alu_out = operand_a;
            default: alu_out = '0;
        endcase
    end

    //////////////////////////////
    // Result register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= exec_valid;
        end
    end

    always_ff @(posedge clock) begin
        result_addr <= exec_dest;
        result_data <= alu_out;
    end

endmodule

//--- src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                clock,
    input  logic                reset,
    input  logic                run,
    input  core_pkg::channel_t  n_channels,
    input  logic                stop_seen,
    input  logic                illegal_seen,
    output core_pkg::pc_t       fetch_addr,
    output logic                issue_valid,
    output core_pkg::channel_t  issue_channel,
    output logic                busy,
    output logic                done,
    output logic                fault
);

    import core_pkg::*;

    pc_t      program_counter;
    channel_t channel;
    channel_t last_channel;
    logic     fetching;
    logic     draining;
    logic     halt;

    // Either flag ends the program
    assign halt = stop_seen || illegal_seen;

    assign fetch_addr = program_counter;

    //////////////////////////////
    // Sequencing
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            program_counter <= '0;
            channel         <= '0;
            last_channel    <= '0;
            fetching        <= 1'b0;
            draining        <= 1'b0;
            issue_valid     <= 1'b0;
            busy            <= 1'b0;
            done            <= 1'b0;
            fault           <= 1'b0;
        end else begin
            done        <= 1'b0;
            // Valid lags the fetch address by the store read latency
            issue_valid <= fetching && !halt;
            if (run && !busy) begin
                program_counter <= '0;
                channel         <= '0;
                last_channel    <= n_channels;
                fetching        <= 1'b1;
                busy            <= 1'b1;
                fault           <= 1'b0;
            end else if (fetching) begin
                if (halt) begin
                    fetching <= 1'b0;
                    draining <= 1'b1;
                    fault    <= illegal_seen;
                end else if (channel == last_channel) begin
                    channel         <= '0;
                    program_counter <= program_counter + 1'b1;
                end else begin
                    channel <= channel + 1'b1;
                end
            end else if (draining) begin
                // Last writeback lands at this edge
                draining <= 1'b0;
                busy     <= 1'b0;
                done     <= !fault;
            end
        end
    end

    always_ff @(posedge clock) begin
        issue_channel <= channel;
    end

endmodule

//--- src/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_DATA_WIDTH-1:0] data_t;
    typedef logic [`CORE_INSTR_WIDTH-1:0] instr_t;
    typedef logic [$clog2(`CORE_PROGRAM_DEPTH)-1:0] pc_t;

    // Channel index, also used for the active channel count minus one
    typedef logic [$clog2(`CORE_MAX_CHANNELS)-1:0] channel_t;
    typedef logic [$clog2(`CORE_REGS_PER_CHANNEL)-1:0] reg_index_t;

    // Channel in the upper bits, register index in the lower bits
    typedef logic [$bits(channel_t)+$bits(reg_index_t)-1:0] reg_addr_t;

    //////////////////////////////
    // Opcodes
    //////////////////////////////

    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,
        OP_ADD  = 5'd1,
        OP_SUB  = 5'd2,
        OP_AND  = 5'd3,
        OP_OR   = 5'd4,
        OP_XOR  = 5'd5,
        OP_SHL  = 5'd6,
        OP_SHR  = 5'd7,
        OP_LDC  = 5'd8,
        OP_MOV  = 5'd9,
        OP_STOP = 5'd10
    } opcode_t;

endpackage

//--- src/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                run,
    input  core_pkg::channel_t  n_channels,
    input  logic                prog_write_valid,
    input  core_pkg::pc_t       prog_write_addr,
    input  core_pkg::instr_t    prog_write_data,
    input  logic                reg_write_valid,
    input  core_pkg::reg_addr_t reg_write_addr,
    input  core_pkg::data_t     reg_write_data,
    input  core_pkg::reg_addr_t reg_read_addr,
    output core_pkg::data_t     reg_read_data,
    output logic                busy,
    output logic                done,
    output logic                fault
);

    import core_pkg::*;

    // Fetch and issue
    pc_t       fetch_addr;
    instr_t    fetch_data;
    logic      issue_valid;
    channel_t  issue_channel;
    logic      stop_seen;
    logic      illegal_seen;

    // Decode to execute
    reg_addr_t read_addr_a;
    reg_addr_t read_addr_b;
    data_t     read_data_a;
    data_t     read_data_b;
    logic      exec_valid;
    opcode_t   exec_opcode;
    reg_addr_t exec_dest;
    data_t     exec_immediate;

    // Writeback
    logic      result_valid;
    reg_addr_t result_addr;
    data_t     result_data;

    //////////////////////////////
    // Pipeline
    //////////////////////////////

    control_unit control (
        .clock(clock), .reset(reset), .run(run), .n_channels(n_channels),
        .stop_seen(stop_seen), .illegal_seen(illegal_seen),
        .fetch_addr(fetch_addr), .issue_valid(issue_valid),
        .issue_channel(issue_channel), .busy(busy), .done(done), .fault(fault)
    );

    instruction_store store (
        .clock(clock), .prog_write_valid(prog_write_valid),
        .prog_write_addr(prog_write_addr), .prog_write_data(prog_write_data),
        .fetch_addr(fetch_addr), .fetch_data(fetch_data)
    );

    decoder decode (
        .clock(clock), .reset(reset), .issue_valid(issue_valid),
        .issue_channel(issue_channel), .instruction(fetch_data),
        .read_addr_a(read_addr_a), .read_addr_b(read_addr_b),
        .exec_valid(exec_valid), .exec_opcode(exec_opcode), .exec_dest(exec_dest),
        .exec_immediate(exec_immediate), .stop_seen(stop_seen),
        .illegal_seen(illegal_seen)
    );

    register_file registers (
        .clock(clock), .read_addr_a(read_addr_a), .read_addr_b(read_addr_b),
        .result_valid(result_valid), .result_addr(result_addr),
        .result_data(result_data), .reg_write_valid(reg_write_valid),
        .reg_write_addr(reg_write_addr), .reg_write_data(reg_write_data),
        .reg_read_addr(reg_read_addr), .read_data_a(read_data_a),
        .read_data_b(read_data_b), .reg_read_data(reg_read_data)
    );

    alu executor (
        .clock(clock), .reset(reset), .exec_valid(exec_valid),
        .exec_opcode(exec_opcode), .exec_dest(exec_dest),
        .exec_immediate(exec_immediate), .operand_a(read_data_a),
        .operand_b(read_data_b), .result_valid(result_valid),
        .result_addr(result_addr), .result_data(result_data)
    );

endmodule

//--- src/decoder.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module decoder (
    input  logic                clock,
    input  logic                reset,
    input  logic                issue_valid,
    input  core_pkg::channel_t  issue_channel,
    input  core_pkg::instr_t    instruction,
    output core_pkg::reg_addr_t read_addr_a,
    output core_pkg::reg_addr_t read_addr_b,
    output logic                exec_valid,
    output core_pkg::opcode_t   exec_opcode,
    output core_pkg::reg_addr_t exec_dest,
    output core_pkg::data_t     exec_immediate,
    output logic                stop_seen,
    output logic                illegal_seen
);

    import core_pkg::*;

    localparam int IMM_WIDTH = `CORE_IMM_MSB - `CORE_IMM_LSB + 1;

    opcode_t    opcode;
    reg_index_t dest_index;
    reg_index_t src_a_index;
    reg_index_t src_b_index;
    data_t      immediate;
    logic       known_opcode;

    //////////////////////////////
    // Field extraction
    //////////////////////////////

    assign opcode      = opcode_t'(instruction[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB]);
    assign dest_index  = instruction[`CORE_DEST_MSB:`CORE_DEST_LSB];
    assign src_a_index = instruction[`CORE_SRC_A_MSB:`CORE_SRC_A_LSB];
    assign src_b_index = instruction[`CORE_SRC_B_MSB:`CORE_SRC_B_LSB];
    assign immediate   = {{(`CORE_DATA_WIDTH-IMM_WIDTH){instruction[`CORE_IMM_MSB]}},
                          instruction[`CORE_IMM_MSB:`CORE_IMM_LSB]};

    // Operand reads go to the issuing channel's bank
    assign read_addr_a = {issue_channel, src_a_index};
    assign read_addr_b = {issue_channel, src_b_index};

    always_comb begin
        case (opcode)
            OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_SHL, OP_SHR, OP_LDC, OP_MOV, OP_STOP: known_opcode = 1'b1;
            default: known_opcode = 1'b0;
        endcase
    end

    assign stop_seen    = issue_valid && (opcode == OP_STOP);
    assign illegal_seen = issue_valid && !known_opcode;

    //////////////////////////////
    // Execute register
    //////////////////////////////

    // Nop, stop and illegal words reach the ALU with valid low
    always_ff @(posedge clock) begin
        if (reset) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= issue_valid && known_opcode
                          && (opcode != OP_STOP) && (opcode != OP_NOP);
        end
    end

    always_ff @(posedge clock) begin
        exec_opcode    <= opcode;
        exec_dest      <= {issue_channel, dest_index};
        exec_immediate <= immediate;
    end

endmodule

//--- src/instruction_store.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module instruction_store (
    input  logic              clock,
    input  logic              prog_write_valid,
    input  core_pkg::pc_t     prog_write_addr,
    input  core_pkg::instr_t  prog_write_data,
    input  core_pkg::pc_t     fetch_addr,
    output core_pkg::instr_t  fetch_data
);

    import core_pkg::*;

    // Program words, kept across reset so a loaded program can be rerun
    instr_t memory [0:`CORE_PROGRAM_DEPTH-1];

    //////////////////////////////
    // Host write port
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (prog_write_valid) begin
            memory[prog_write_addr] <= prog_write_data;
        end
    end

    //////////////////////////////
    // Fetch port
    //////////////////////////////

    // Registered read, data follows the address by one cycle
    always_ff @(posedge clock) begin
        fetch_data <= memory[fetch_addr];
    end

endmodule

//--- src/register_file.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module register_file (
    input  logic                clock,
    input  core_pkg::reg_addr_t read_addr_a,
    input  core_pkg::reg_addr_t read_addr_b,
    input  logic                result_valid,
    input  core_pkg::reg_addr_t result_addr,
    input  core_pkg::data_t     result_data,
    input  logic                reg_write_valid,
    input  core_pkg::reg_addr_t reg_write_addr,
    input  core_pkg::data_t     reg_write_data,
    input  core_pkg::reg_addr_t reg_read_addr,
    output core_pkg::data_t     read_data_a,
    output core_pkg::data_t     read_data_b,
    output core_pkg::data_t     reg_read_data
);

    import core_pkg::*;

    localparam int FILE_DEPTH = `CORE_REGS_PER_CHANNEL * `CORE_MAX_CHANNELS;

    // All channel banks, bank n at addresses n*16 up
    data_t registers [0:FILE_DEPTH-1];

    logic      write_enable;
    reg_addr_t write_addr;
    data_t     write_data;

    //////////////////////////////
    // Write port
    //////////////////////////////

    // ALU writeback has priority over the host
    assign write_enable = result_valid || reg_write_valid;
    assign write_addr   = result_valid ? result_addr : reg_write_addr;
    assign write_data   = result_valid ? result_data : reg_write_data;

    always_ff @(posedge clock) begin
        if (write_enable) begin
            registers[write_addr] <= write_data;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // Reads see the old value on a same-edge write
    always_ff @(posedge clock) begin
        read_data_a   <= registers[read_addr_a];
        read_data_b   <= registers[read_addr_b];
        reg_read_data <= registers[reg_read_addr];
    end

endmodule

//--- verif/core_tb.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb;

    import core_pkg::*;

    localparam int CLOCK_PERIOD   = 8;
    localparam int FILE_DEPTH     = `CORE_REGS_PER_CHANNEL * `CORE_MAX_CHANNELS;
    localparam int IMM_WIDTH      = `CORE_IMM_MSB - `CORE_IMM_LSB + 1;
    localparam int ALL_OPS_LENGTH = 13;
    localparam int STOP_LENGTH    = 4;
    localparam int FAULT_LENGTH   = 5;
    localparam int TEST_COUNT     = 5;
    localparam int MARGIN_CYCLES  = 400;
    // One issue slot per program word and active channel in every run
    localparam int WATCHDOG_CYCLES = ALL_OPS_LENGTH * 1 + ALL_OPS_LENGTH * 4
        + STOP_LENGTH * 2 * 2 + FAULT_LENGTH * 1 + STOP_LENGTH * 1
        + TEST_COUNT * MARGIN_CYCLES;

    logic      clock;
    logic      reset;
    logic      run;
    channel_t  n_channels;
    logic      prog_write_valid;
    pc_t       prog_write_addr;
    instr_t    prog_write_data;
    logic      reg_write_valid;
    reg_addr_t reg_write_addr;
    data_t     reg_write_data;
    reg_addr_t reg_read_addr;
    data_t     reg_read_data;
    logic      busy;
    logic      done;
    logic      fault;

    instr_t program_words [$];
    data_t  model_regs [0:FILE_DEPTH-1];
    int     error_count = 0;
    int     pass_count  = 0;
    int     fail_count  = 0;
    int     done_count  = 0;

    core_top dut0 (
        .clock(clock), .reset(reset), .run(run), .n_channels(n_channels),
        .prog_write_valid(prog_write_valid), .prog_write_addr(prog_write_addr),
        .prog_write_data(prog_write_data), .reg_write_valid(reg_write_valid),
        .reg_write_addr(reg_write_addr), .reg_write_data(reg_write_data),
        .reg_read_addr(reg_read_addr), .reg_read_data(reg_read_data),
        .busy(busy), .done(done), .fault(fault)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    function automatic void report_failure(input string message);
        $display("ERROR %s", message);
        error_count++;
    endfunction

    function automatic void check_condition(input logic condition, input string message);
        assert (condition) else report_failure(message);
    endfunction

    function automatic void check_value(input string name, input data_t expected,
                                        input data_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endfunction

    // Done is one cycle wide and only comes with busy and fault low
    done_single_cycle: assert property (@(posedge clock) disable iff (reset) done |=> !done)
        else report_failure("done stayed high for more than one cycle");
    done_when_idle: assert property (@(posedge clock) disable iff (reset)
                                     done |-> !busy && !fault)
        else report_failure("done pulsed while busy or fault was high");

    function automatic void finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endfunction

    //////////////////////////////
    // Programs and model
    //////////////////////////////

    function automatic void add_word(input int op, input int dest, input int src_a,
                                     input int src_b, input int imm);
        instr_t word;
        word = '0;
        word[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB] = 5'(op);
        word[`CORE_DEST_MSB:`CORE_DEST_LSB]     = reg_index_t'(dest);
        word[`CORE_SRC_A_MSB:`CORE_SRC_A_LSB]   = reg_index_t'(src_a);
        word[`CORE_SRC_B_MSB:`CORE_SRC_B_LSB]   = reg_index_t'(src_b);
        word[`CORE_IMM_MSB:`CORE_IMM_LSB]       = IMM_WIDTH'(imm);
        program_words.push_back(word);
    endfunction

    function automatic void build_all_ops_program();
        program_words.delete();
        add_word(OP_ADD, 8, 0, 1, 0);
        add_word(OP_SUB, 9, 2, 3, 0);
        add_word(OP_AND, 10, 4, 5, 0);
        add_word(OP_OR, 11, 6, 7, 0);
        add_word(OP_XOR, 12, 0, 7, 0);
        add_word(OP_SHL, 13, 1, 2, 0);
        add_word(OP_SHR, 14, 3, 4, 0);
        add_word(OP_LDC, 15, 0, 0, 'h4a5c);
        // Two slots before r15 is read back
        add_word(OP_NOP, 0, 0, 0, 0);
        add_word(OP_NOP, 0, 0, 0, 0);
        add_word(OP_MOV, 6, 15, 0, 0);
        add_word(OP_STOP, 0, 0, 0, 0);
        add_word(OP_LDC, 0, 0, 0, 'h0011);
    endfunction

    function automatic void build_stop_program();
        program_words.delete();
        add_word(OP_ADD, 8, 0, 1, 0);
        add_word(OP_STOP, 0, 0, 0, 0);
        add_word(OP_LDC, 9, 0, 0, 'h0123);
        add_word(OP_MOV, 10, 2, 0, 0);
    endfunction

    function automatic void build_fault_program();
        program_words.delete();
        add_word(OP_SUB, 8, 0, 1, 0);
        add_word(OP_XOR, 9, 2, 3, 0);
        add_word('h1f, 10, 0, 1, 0);
        add_word(OP_LDC, 11, 0, 0, 'h0077);
        add_word(OP_STOP, 0, 0, 0, 0);
    endfunction

    // Runs the program in order on each active bank until stop or an undefined opcode
    function automatic void apply_model(input channel_t last_channel);
        instr_t   word;
        channel_t channel;
        data_t    a;
        data_t    b;
        data_t    result;
        logic     writes;
        logic     halted;
        for (int ch = 0; ch <= int'(last_channel); ch++) begin
            channel = channel_t'(ch);
            halted  = 1'b0;
            for (int pc = 0; pc < program_words.size() && !halted; pc++) begin
                word   = program_words[pc];
                a      = model_regs[{channel, word[`CORE_SRC_A_MSB:`CORE_SRC_A_LSB]}];
                b      = model_regs[{channel, word[`CORE_SRC_B_MSB:`CORE_SRC_B_LSB]}];
                writes = 1'b1;
                result = '0;
                case (word[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB])
                    OP_ADD:  result = a + b;
                    OP_SUB:  result = a - b;
                    OP_AND:  result = a & b;
                    OP_OR:   result = a | b;
                    OP_XOR:  result = a ^ b;
                    OP_SHL:  result = a << b[4:0];
                    OP_SHR:  result = a >> b[4:0];
                    OP_LDC:  result = data_t'($signed(word[`CORE_IMM_MSB:`CORE_IMM_LSB]));
                    OP_MOV:  result = a;
                    OP_NOP:  writes = 1'b0;
                    default: begin
                        writes = 1'b0;
                        halted = 1'b1;
                    end
                endcase
                if (writes) begin
                    model_regs[{channel, word[`CORE_DEST_MSB:`CORE_DEST_LSB]}] = result;
                end
            end
        end
    endfunction

    //////////////////////////////
    // Host access
    //////////////////////////////

    task automatic load_program();
        for (int i = 0; i < program_words.size(); i++) begin
            prog_write_valid = 1'b1;
            prog_write_addr  = pc_t'(i);
            prog_write_data  = program_words[i];
            @(negedge clock);
        end
        prog_write_valid = 1'b0;
    endtask

    task automatic preload_registers();
        reg_addr_t addr;
        for (int i = 0; i < FILE_DEPTH; i++) begin
            addr             = reg_addr_t'(i);
            model_regs[addr] = $urandom;
            reg_write_valid  = 1'b1;
            reg_write_addr   = addr;
            reg_write_data   = model_regs[addr];
            @(negedge clock);
        end
        reg_write_valid = 1'b0;
    endtask

    task automatic check_registers(input string name);
        reg_addr_t addr;
        for (int i = 0; i < FILE_DEPTH; i++) begin
            addr          = reg_addr_t'(i);
            reg_read_addr = addr;
            @(negedge clock);
            check_value($sformatf("%s reg %0d", name, i), model_regs[addr], reg_read_data);
        end
    endtask

    // Pulses run and counts done pulses until busy falls
    task automatic run_program(input channel_t last_channel);
        n_channels = last_channel;
        done_count = 0;
        run        = 1'b1;
        @(negedge clock);
        run = 1'b0;
        check_condition(busy, "busy did not rise after run");
        while (busy) begin
            @(negedge clock);
            if (done) begin
                done_count++;
            end
        end
        @(negedge clock);
        if (done) begin
            done_count++;
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int        errors_before;
        data_t     sample;
        reg_addr_t sample_addr;
        void'($urandom(32'h3223));
        reset            = 1'b1;
        run              = 1'b0;
        n_channels       = '0;
        prog_write_valid = 1'b0;
        prog_write_addr  = '0;
        prog_write_data  = '0;
        reg_write_valid  = 1'b0;
        reg_write_addr   = '0;
        reg_write_data   = '0;
        reg_read_addr    = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        errors_before = error_count;
        check_condition(!busy && !done && !fault, "busy, done or fault high after reset");
        check_condition(!dut0.result_valid, "writeback strobe active after reset");
        sample          = $urandom;
        sample_addr     = reg_addr_t'($urandom);
        reg_write_valid = 1'b1;
        reg_write_addr  = sample_addr;
        reg_write_data  = sample;
        @(negedge clock);
        reg_write_valid = 1'b0;
        reg_read_addr   = sample_addr;
        @(negedge clock);
        check_value("reset_and_host_access", sample, reg_read_data);
        finish_test("reset_and_host_access", errors_before);

        errors_before = error_count;
        build_all_ops_program();
        load_program();
        preload_registers();
        apply_model(channel_t'(0));
        run_program(channel_t'(0));
        check_condition(done_count == 1, "done did not pulse exactly once");
        check_registers("single_channel_all_ops");
        finish_test("single_channel_all_ops", errors_before);

        errors_before = error_count;
        preload_registers();
        apply_model(channel_t'(3));
        run_program(channel_t'(3));
        check_condition(done_count == 1, "done did not pulse exactly once");
        check_registers("four_channels_all_ops");
        finish_test("four_channels_all_ops", errors_before);

        errors_before = error_count;
        build_stop_program();
        load_program();
        preload_registers();
        apply_model(channel_t'(1));
        run_program(channel_t'(1));
        check_condition(done_count == 1, "done did not pulse once on the first run");
        check_registers("stop_and_rerun");
        // Overwrite r8 in both active banks so the rerun has to write it again
        for (int ch = 0; ch < 2; ch++) begin
            reg_write_valid = 1'b1;
            reg_write_addr  = {channel_t'(ch), reg_index_t'(8)};
            reg_write_data  = ~model_regs[{channel_t'(ch), reg_index_t'(8)}];
            @(negedge clock);
        end
        reg_write_valid = 1'b0;
        run_program(channel_t'(1));
        check_condition(done_count == 1, "done did not pulse once on the second run");
        check_registers("stop_and_rerun");
        finish_test("stop_and_rerun", errors_before);

        errors_before = error_count;
        build_fault_program();
        load_program();
        preload_registers();
        apply_model(channel_t'(0));
        run_program(channel_t'(0));
        check_condition(done_count == 0, "done pulsed on a program with an illegal opcode");
        check_registers("illegal_opcode_fault");
        check_condition(fault, "fault not held high after an illegal opcode");
        build_stop_program();
        load_program();
        apply_model(channel_t'(0));
        run_program(channel_t'(0));
        check_condition(!fault, "fault not cleared by the next run");
        check_condition(done_count == 1, "done did not pulse after the fault was cleared");
        finish_test("illegal_opcode_fault", errors_before);

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
